// ==== src.f ====
verilog/pcs_tx_pkg.sv
verilog/symbol_encoder.sv
verilog/running_disparity.sv
verilog/ordered_set_fsm.sv
verilog/pcs_tx_code_group.sv
verification/pcs_tx_chk.sv
verification/tb_pcs_tx.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the testbench with Verilator, then search the log for the fail message

rm -f sim.log \
    && verilator --binary --timing --assert --top-module tb_pcs_tx -f src.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_pcs_tx +verilator+error+limit+1000 >> sim.log 2>&1 \
    || echo "Finished with errors" >> sim.log

cat sim.log

grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// ==== verification/tb_pcs_tx.sv ====
`timescale 1ns/1ps

module tb_pcs_tx;
    import pcs_tx_pkg::*;

    localparam logic [31:0] SEED            = 32'h15a75e76;
    localparam int          NUM_REQUESTS    = 400;
    localparam int          WATCHDOG_CYCLES = 20000;
    localparam int          DONE_TIMEOUT    = 8;
    localparam octet_t      NO_REQUEST      = 8'h00;
    localparam octet_t      UNKNOWN_CODE    = 8'h1C;   // Not an ordered-set code

    logic        clk;
    logic        reset;
    logic        power_on;
    octet_t      tx_o_set;
    octet_t      data_o_set;
    logic [9:0]  tx_code_group;
    logic        tx_oset_indicate;
    logic        tx_even;
    logic [31:0] lfsr_state;

    pcs_tx_code_group UUT (
        .clk              (clk),
        .reset            (reset),
        .power_on         (power_on),
        .tx_o_set         (tx_o_set),
        .data_o_set       (data_o_set),
        .tx_code_group    (tx_code_group),
        .tx_oset_indicate (tx_oset_indicate),
        .tx_even          (tx_even)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Random stimulus
    //////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'hD0000001;
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int count, output logic [7:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic pick_request(output octet_t oset, output octet_t oct, output logic pwr);
        logic [7:0] sel;
        logic [7:0] v;
        logic [7:0] p;
        draw_bits(4, sel);
        draw_bits(4, v);
        draw_bits(3, p);
        oct = (v > 8'd12) ? v - 8'd3 : v;   // Octets 0 to 12
        pwr = (p != 8'd0);                  // Dropped about one time in eight
        if (sel < 8'd4)
            oset = OSET_IDLE;
        else if (sel < 8'd10)
            oset = OSET_DATA;
        else if (sel == 8'd10)
            oset = OSET_START;
        else if (sel == 8'd11)
            oset = OSET_END;
        else if (sel == 8'd12)
            oset = OSET_CARRIER;
        else
            oset = UNKNOWN_CODE;
    endtask

    function automatic logic request_known(input octet_t oset, input octet_t oct);
        return (oset == OSET_IDLE) || (oset == OSET_START) || (oset == OSET_END) ||
               (oset == OSET_CARRIER) ||
               (oset == OSET_DATA && oct < octet_t'(NUM_DATA_OCTETS));
    endfunction

    // Presents a request for one cycle, then waits for the set to finish
    task automatic send_request(input octet_t oset, input octet_t oct, input logic pwr);
        int   wait_count;
        logic done;
        tx_o_set   <= oset;
        data_o_set <= oct;
        power_on   <= pwr;
        @(posedge clk);                     // Request sampled here
        tx_o_set <= NO_REQUEST;
        power_on <= 1'b1;
        if (pwr && request_known(oset, oct))
        begin
            done       = 1'b0;
            wait_count = 0;
            while (!done && wait_count < DONE_TIMEOUT)
            begin
                @(posedge clk);
                done       = tx_oset_indicate;
                wait_count = wait_count + 1;
            end
            if (!done)
            begin
                $display("Finished with errors");
                $fatal(1, "No tx_oset_indicate within %0d cycles of a request", DONE_TIMEOUT);
            end
        end
        else
            repeat (3) @(posedge clk);      // Refused, output checked two edges on
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        octet_t oset;
        octet_t oct;
        logic   pwr;
        int     n;
        lfsr_state = SEED;
        reset      = 1'b0;
        power_on   = 1'b0;
        tx_o_set   = NO_REQUEST;
        data_o_set = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        for (n = 0; n < NUM_REQUESTS; n++)
        begin
            pick_request(oset, oct, pwr);
            send_request(oset, oct, pwr);
        end
        repeat (4) @(posedge clk);
        if (!UUT.u_chk.error_seen)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            $display("Finished with errors");
            $fatal(1, "A checker assertion failed");
        end
    end

    // Stop at the first failed assertion
    always @(negedge clk)
    begin
        if (UUT.u_chk.error_seen)
        begin
            $display("Finished with errors");
            $fatal(1, "A checker assertion failed");
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Finished with errors");
        $fatal(1, "Simulation did not end within %0d cycles", WATCHDOG_CYCLES);
    end

endmodule

// ==== verification/pcs_tx_chk.sv ====
`timescale 1ns/1ps

module pcs_tx_chk (
    input  logic               clk,
    input  logic               reset,
    input  logic               power_on,
    input  pcs_tx_pkg::octet_t tx_o_set,
    input  pcs_tx_pkg::octet_t data_o_set,
    input  logic [9:0]         tx_code_group,
    input  logic               tx_oset_indicate,
    input  logic               tx_even
);
    import pcs_tx_pkg::*;

    // Reference model states
    localparam logic [1:0] M_READY  = 2'd0;
    localparam logic [1:0] M_IDLE_K = 2'd1;
    localparam logic [1:0] M_IDLE_D = 2'd2;
    localparam logic [1:0] M_SINGLE = 2'd3;

    // Kind of the group on the output
    localparam logic [1:0] KIND_DATA    = 2'd0;
    localparam logic [1:0] KIND_SPECIAL = 2'd1;
    localparam logic [1:0] KIND_IDLE_K  = 2'd2;
    localparam logic [1:0] KIND_IDLE_D  = 2'd3;

    logic [1:0] m_state;
    octet_t     req_oset;
    octet_t     req_octet;
    logic       acc_rd;       // Shadow disparity at acceptance
    logic       shadow_rd;    // Disparity before the group on the output
    logic       rd_now;
    logic       new_cg;       // A new group is on the output
    logic [1:0] new_kind;
    logic [9:0] prev_cg;
    logic       prev_even;
    logic       in_reset_q;
    logic       req_known;
    logic [9:0] exp_cg;
    logic       exp_even;
    logic       exp_indicate;

    logic fail_reset = 1'b0;
    logic fail_cg    = 1'b0;
    logic fail_ind   = 1'b0;
    logic fail_even  = 1'b0;
    logic fail_bound = 1'b0;
    logic error_seen;

    function automatic int ones_in(input logic [9:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 10; i++)
            n = n + int'(v[i]);
        return n;
    endfunction

    // Sub-block rule, six bits first, then four bits
    function automatic logic rd_after(input logic rd_in, input logic [9:0] cg);
        logic r;
        int   n6;
        int   n4;
        r  = rd_in;
        n6 = ones_in({4'b0000, cg[9:4]});
        n4 = ones_in({6'b000000, cg[3:0]});
        if (n6 > 3 || cg[9:4] == 6'b000111)
            r = 1'b1;
        else if (n6 < 3 || cg[9:4] == 6'b111000)
            r = 1'b0;
        if (n4 > 2 || cg[3:0] == 4'b0011)
            r = 1'b1;
        else if (n4 < 2 || cg[3:0] == 4'b1100)
            r = 1'b0;
        return r;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    assign req_known = (tx_o_set == OSET_IDLE) || (tx_o_set == OSET_START) ||
                       (tx_o_set == OSET_END) || (tx_o_set == OSET_CARRIER) ||
                       (tx_o_set == OSET_DATA && data_o_set < octet_t'(NUM_DATA_OCTETS));

    assign rd_now = new_cg ? rd_after(shadow_rd, tx_code_group) : shadow_rd;

    always_ff @(posedge clk)
    begin
        prev_cg    <= tx_code_group;
        prev_even  <= tx_even;
        in_reset_q <= !reset;
        if (!reset)
        begin
            m_state   <= M_READY;
            new_cg    <= 1'b0;
            new_kind  <= KIND_DATA;
            shadow_rd <= 1'b0;
            acc_rd    <= 1'b0;
        end
        else
        begin
            shadow_rd <= rd_now;
            new_cg    <= (m_state != M_READY);
            case (m_state)
                M_READY:
                begin
                    if (power_on && req_known)
                    begin
                        req_oset  <= tx_o_set;
                        req_octet <= data_o_set;
                        acc_rd    <= rd_now;
                        m_state   <= (tx_o_set == OSET_IDLE) ? M_IDLE_K : M_SINGLE;
                    end
                end
                M_IDLE_K:
                begin
                    new_kind <= KIND_IDLE_K;
                    m_state  <= M_IDLE_D;
                end
                M_IDLE_D:
                begin
                    new_kind <= KIND_IDLE_D;
                    m_state  <= M_READY;
                end
                default:
                begin
                    new_kind <= (req_oset == OSET_DATA) ? KIND_DATA : KIND_SPECIAL;
                    m_state  <= M_READY;
                end
            endcase
        end
    end

    always_comb
    begin
        exp_cg = prev_cg;   // Nothing new, output holds
        if (new_cg)
        begin
            case (new_kind)
                KIND_IDLE_K: exp_cg = shadow_rd ? CG_K28_5_RDP : CG_K28_5_RDN;
                KIND_IDLE_D: exp_cg = acc_rd ? CG_D5_6 :
                                      (shadow_rd ? CG_D16_2_RDP : CG_D16_2_RDN);
                KIND_DATA:   exp_cg = shadow_rd ? CG_DATA_RDP[req_octet[3:0]] :
                                                  CG_DATA_RDN[req_octet[3:0]];
                default:
                begin
                    if (req_oset == OSET_START)
                        exp_cg = shadow_rd ? CG_S_RDP : CG_S_RDN;
                    else if (req_oset == OSET_END)
                        exp_cg = shadow_rd ? CG_T_RDP : CG_T_RDN;
                    else
                        exp_cg = shadow_rd ? CG_R_RDP : CG_R_RDN;
                end
            endcase
        end
    end

    assign exp_even     = new_cg ? ((new_kind == KIND_IDLE_K) ? 1'b1 : !prev_even) : prev_even;
    assign exp_indicate = new_cg && (new_kind != KIND_IDLE_K);
    assign error_seen   = fail_reset | fail_cg | fail_ind | fail_even | fail_bound;

    //////////////////////////////
    // Assertions
    //////////////////////////////

    a_reset_values: assert property (@(posedge clk)
        in_reset_q |-> (tx_code_group == '0 && !tx_oset_indicate && !tx_even))
    else
    begin
        fail_reset = 1'b1;
        $error("Outputs are not cleared while reset is asserted");
    end

    a_code_group: assert property (@(posedge clk) disable iff (!reset)
        tx_code_group == exp_cg)
    else
    begin
        fail_cg = 1'b1;
        $error("error %0t tx_code_group got %b expected %b",
               $time, $sampled(tx_code_group), $sampled(exp_cg));
    end

    a_indicate: assert property (@(posedge clk) disable iff (!reset)
        tx_oset_indicate == exp_indicate)
    else
    begin
        fail_ind = 1'b1;
        $error("error %0t tx_oset_indicate got %b expected %b",
               $time, $sampled(tx_oset_indicate), $sampled(exp_indicate));
    end

    a_even: assert property (@(posedge clk) disable iff (!reset)
        tx_even == exp_even)
    else
    begin
        fail_even = 1'b1;
        $error("error %0t tx_even got %b expected %b",
               $time, $sampled(tx_even), $sampled(exp_even));
    end

    // At least five ones from negative, at most five from positive
    a_disparity_bound: assert property (@(posedge clk) disable iff (!reset)
        new_cg |-> (shadow_rd ? ones_in(tx_code_group) <= 5 : ones_in(tx_code_group) >= 5))
    else
    begin
        fail_bound = 1'b1;
        $error("Code group %b breaks the running disparity bound", $sampled(tx_code_group));
    end

endmodule

bind pcs_tx_code_group pcs_tx_chk u_chk (
    .clk              (clk),
    .reset            (reset),
    .power_on         (power_on),
    .tx_o_set         (tx_o_set),
    .data_o_set       (data_o_set),
    .tx_code_group    (tx_code_group),
    .tx_oset_indicate (tx_oset_indicate),
    .tx_even          (tx_even)
);

// ==== verilog/pcs_tx_code_group.sv ====
`timescale 1ns/1ps

module pcs_tx_code_group (
    input  logic               clk,
    input  logic               reset,
    input  logic               power_on,
    input  pcs_tx_pkg::octet_t tx_o_set,
    input  pcs_tx_pkg::octet_t data_o_set,
    output logic [9:0]         tx_code_group,
    output logic               tx_oset_indicate,
    output logic               tx_even
);
    import pcs_tx_pkg::*;

    symbol_t        symbol;
    encode_result_t result;
    logic           rd;        // 1 is positive
    logic           advance;

    ordered_set_fsm u_fsm (
        .clk              (clk),
        .reset            (reset),
        .power_on         (power_on),
        .tx_o_set         (tx_o_set),
        .data_o_set       (data_o_set),
        .rd               (rd),
        .result           (result),
        .symbol           (symbol),
        .advance          (advance),
        .tx_code_group    (tx_code_group),
        .tx_oset_indicate (tx_oset_indicate),
        .tx_even          (tx_even)
    );

    symbol_encoder u_encoder (
        .symbol (symbol),
        .rd     (rd),
        .result (result)
    );

    // Loads the disparity of the group emitted this cycle
    running_disparity u_rd (
        .clk        (clk),
        .reset      (reset),
        .advance    (advance),
        .code_group (result.code_group),
        .rd         (rd)
    );

endmodule

// ==== verilog/ordered_set_fsm.sv ====
`timescale 1ns/1ps

module ordered_set_fsm (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       power_on,
    input  pcs_tx_pkg::octet_t         tx_o_set,
    input  pcs_tx_pkg::octet_t         data_o_set,
    input  logic                       rd,
    input  pcs_tx_pkg::encode_result_t result,
    output pcs_tx_pkg::symbol_t        symbol,
    output logic                       advance,
    output logic [9:0]                 tx_code_group,
    output logic                       tx_oset_indicate,
    output logic                       tx_even
);
    import pcs_tx_pkg::*;

    // One-hot state encoding
    localparam logic [4:0] GENERATE   = 5'b00001;
    localparam logic [4:0] IDLE_K     = 5'b00010;
    localparam logic [4:0] IDLE_D     = 5'b00100;
    localparam logic [4:0] DATA_GO    = 5'b01000;
    localparam logic [4:0] SPECIAL_GO = 5'b10000;

    logic [4:0] state;
    logic [4:0] next_state;
    symbol_t    req_symbol;   // Request decoded from the inputs
    symbol_t    sym_q;        // Symbol of the accepted request
    logic       use_d5_6;     // Idle second group, taken from rd at accept
    logic       req_idle;
    logic       req_data;
    logic       req_ok;
    logic       last_cg;

    //////////////////////////////
    // Request decode
    //////////////////////////////

    assign req_idle = (tx_o_set == OSET_IDLE);
    assign req_data = (tx_o_set == OSET_DATA);

    always_comb
    begin
        if (req_idle)
            req_symbol = '{octet: OCTET_K28_5, is_control: 1'b1};
        else if (req_data)
            req_symbol = '{octet: data_o_set, is_control: 1'b0};
        else
            req_symbol = '{octet: tx_o_set, is_control: 1'b1};   // S, T, R or unknown
    end

    // D5.6 and D16.2 are known to the encoder, but only D0 to D9 may be requested
    assign req_ok = result.known &&
                    !(req_data && data_o_set >= octet_t'(NUM_DATA_OCTETS));

    // Symbol shown to the encoder in each state
    always_comb
    begin
        case (state)
            GENERATE: symbol = req_symbol;
            IDLE_D:   symbol = '{octet: use_d5_6 ? OCTET_D5_6 : OCTET_D16_2,
                                 is_control: 1'b0};
            default:  symbol = sym_q;
        endcase
    end

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            GENERATE:
            begin
                if (power_on && req_ok)
                begin
                    if (req_idle)
                        next_state = IDLE_K;
                    else if (req_data)
                        next_state = DATA_GO;
                    else
                        next_state = SPECIAL_GO;
                end
            end
            IDLE_K:     next_state = IDLE_D;
            IDLE_D:     next_state = GENERATE;
            DATA_GO:    next_state = GENERATE;
            SPECIAL_GO: next_state = GENERATE;
            default:    next_state = GENERATE;   // Recover from an illegal code
        endcase
    end

    // Every state but GENERATE emits one code group
    assign advance = (state == IDLE_K) || (state == IDLE_D) ||
                     (state == DATA_GO) || (state == SPECIAL_GO);

    // Last group of its set
    assign last_cg = advance && (state != IDLE_K);

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state            <= GENERATE;
            tx_code_group    <= '0;
            tx_oset_indicate <= 1'b0;
            tx_even          <= 1'b0;
        end
        else
        begin
            state            <= next_state;
            tx_oset_indicate <= last_cg;
            if (advance)
            begin
                tx_code_group <= result.code_group.raw;
                tx_even       <= (state == IDLE_K) ? 1'b1 : !tx_even;   // K28.5 is even
            end
        end
    end

    // Request payload, held while the set is sent
    always_ff @(posedge clk)
    begin
        if (state == GENERATE)
        begin
            sym_q    <= req_symbol;
            use_d5_6 <= rd;   // Positive at the start of the set selects D5.6
        end
    end

endmodule

// ==== verilog/running_disparity.sv ====
`timescale 1ns/1ps

module running_disparity (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    advance,
    input  pcs_tx_pkg::code_group_u code_group,
    output logic                    rd
);

    logic rd_mid;    // Disparity at the end of the six-bit sub-block
    logic rd_next;

    //////////////////////////////
    // Sub-block rule
    //////////////////////////////

    always_comb
    begin
        // Six-bit sub-block starts from the current disparity
        if ($countones(code_group.sub_blocks.six) > 3 ||
            code_group.sub_blocks.six == 6'b000111)
        begin
            rd_mid = 1'b1;
        end
        else if ($countones(code_group.sub_blocks.six) < 3 ||
                 code_group.sub_blocks.six == 6'b111000)
        begin
            rd_mid = 1'b0;
        end
        else
        begin
            rd_mid = rd;   // Neutral block
        end

        // Four-bit sub-block continues from rd_mid
        if ($countones(code_group.sub_blocks.four) > 2 ||
            code_group.sub_blocks.four == 4'b0011)
        begin
            rd_next = 1'b1;
        end
        else if ($countones(code_group.sub_blocks.four) < 2 ||
                 code_group.sub_blocks.four == 4'b1100)
        begin
            rd_next = 1'b0;
        end
        else
        begin
            rd_next = rd_mid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            rd <= 1'b0;        // Start negative
        else if (advance)
            rd <= rd_next;
    end

endmodule

// ==== verilog/symbol_encoder.sv ====
`timescale 1ns/1ps

module symbol_encoder (
    input  pcs_tx_pkg::symbol_t        symbol,
    input  logic                       rd,
    output pcs_tx_pkg::encode_result_t result
);
    import pcs_tx_pkg::*;

    logic [9:0] cg;
    logic       known;

    //////////////////////////////
    // Table lookup
    //////////////////////////////

    always_comb
    begin
        cg    = '0;
        known = 1'b1;

        if (symbol.is_control)
        begin
            case (symbol.octet)
                OCTET_K28_5:
                begin
                    cg = rd ? CG_K28_5_RDP : CG_K28_5_RDN;
                end
                OSET_START:
                begin
                    cg = rd ? CG_S_RDP : CG_S_RDN;
                end
                OSET_END:
                begin
                    cg = rd ? CG_T_RDP : CG_T_RDN;
                end
                OSET_CARRIER:
                begin
                    cg = rd ? CG_R_RDP : CG_R_RDN;
                end
                default:
                begin
                    known = 1'b0;   // No such K code group here
                end
            endcase
        end
        else if (symbol.octet < octet_t'(NUM_DATA_OCTETS))
        begin
            // Low nibble is enough once the range is known
            if (rd)
            begin
                cg = CG_DATA_RDP[symbol.octet[3:0]];
            end
            else
            begin
                cg = CG_DATA_RDN[symbol.octet[3:0]];
            end
        end
        else if (symbol.octet == OCTET_D5_6)
        begin
            cg = CG_D5_6;   // Balanced, one entry serves both columns
        end
        else if (symbol.octet == OCTET_D16_2)
        begin
            cg = rd ? CG_D16_2_RDP : CG_D16_2_RDN;
        end
        else
        begin
            known = 1'b0;
        end
    end

    assign result.code_group.raw = cg;
    assign result.known          = known;

endmodule

// ==== verilog/pcs_tx_pkg.sv ====
package pcs_tx_pkg;

    typedef logic [7:0] octet_t;

    //////////////////////////////
    // Ordered-set request codes
    //////////////////////////////

    localparam octet_t OSET_IDLE    = 8'hBC;
    localparam octet_t OSET_DATA    = 8'hFF;
    localparam octet_t OSET_START   = 8'hFB;   // /S/
    localparam octet_t OSET_END     = 8'hFD;   // /T/
    localparam octet_t OSET_CARRIER = 8'hF7;   // /R/

    // Octets used inside the idle set
    localparam octet_t OCTET_K28_5 = 8'hBC;
    localparam octet_t OCTET_D5_6  = 8'hC5;
    localparam octet_t OCTET_D16_2 = 8'h50;

    localparam int NUM_DATA_OCTETS = 10;   // D0 to D9

    //////////////////////////////
    // Code-group table
    //////////////////////////////

    localparam logic [9:0] CG_K28_5_RDN = 10'b0011111010;
    localparam logic [9:0] CG_K28_5_RDP = 10'b1100000101;

    localparam logic [9:0] CG_D5_6      = 10'b1010010110;   // Same in both columns

    localparam logic [9:0] CG_D16_2_RDN = 10'b0110110101;
    localparam logic [9:0] CG_D16_2_RDP = 10'b1001000101;

    localparam logic [9:0] CG_S_RDN     = 10'b1101101000;
    localparam logic [9:0] CG_S_RDP     = 10'b0010010111;

    localparam logic [9:0] CG_T_RDN     = 10'b1011101000;
    localparam logic [9:0] CG_T_RDP     = 10'b0100010111;

    localparam logic [9:0] CG_R_RDN     = 10'b1110101000;
    localparam logic [9:0] CG_R_RDP     = 10'b0001010111;

    // Data column for negative running disparity indexed by octet
    localparam logic [9:0] CG_DATA_RDN [NUM_DATA_OCTETS] = '{
        10'b1001110100,   // D0
        10'b0111010100,   // D1
        10'b1011010100,   // D2
        10'b1100011011,   // D3
        10'b1101010100,   // D4
        10'b1010011011,   // D5
        10'b0110011011,   // D6
        10'b1110001011,   // D7
        10'b1110010100,   // D8
        10'b1001011011    // D9
    };

    // Data column for positive running disparity
    localparam logic [9:0] CG_DATA_RDP [NUM_DATA_OCTETS] = '{
        10'b0110001011,   // D0
        10'b1000101011,   // D1
        10'b0100101011,   // D2
        10'b1100010100,   // D3
        10'b0010101011,   // D4
        10'b1010010100,   // D5
        10'b0110010100,   // D6
        10'b0001110100,   // D7
        10'b0001101011,   // D8
        10'b1001010100    // D9
    };

    //////////////////////////////
    // Types
    //////////////////////////////

    // What the encoder is asked to produce
    typedef struct packed {
        octet_t octet;
        logic   is_control;   // K code group when set
    } symbol_t;

    // Sub-blocks in line order with abcdei first
    typedef struct packed {
        logic [5:0] six;
        logic [3:0] four;
    } sub_blocks_t;

    typedef union packed {
        logic [9:0]  raw;
        sub_blocks_t sub_blocks;
    } code_group_u;

    typedef struct packed {
        code_group_u code_group;
        logic        known;   // Symbol was found in the table
    } encode_result_t;

endpackage
